// ==== list.f ====
hw/fpga_pkg.sv
hw/key_debounce.sv
hw/reset_req_pulse.sv
hw/heartbeat_led.sv
hw/pio_axil_regs.sv
hw/ghrd_fabric_top.sv
sim/ghrd_fabric_asserts.sv
sim/tb_ghrd_fabric.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        := tb_ghrd_fabric
RTL_TOP    := ghrd_fabric_top
FILELIST   := list.f
BUILD_DIR  := obj_dir
SIM_BIN    := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/tb_ghrd_fabric.sv ====
/*
  Testbench for the fabric side of the SoC board top level.
  Drives AXI4-Lite writes and reads, switches and bouncing keys into the
  DUT, keeps its own model of the registers and checks read data, LEDs,
  trace word, reset-request pulses and the heartbeat.
  Prints one line per test and a closing count line.
*/
`timescale 1ns/1ns

module tb_ghrd_fabric
  import fpga_pkg::*;
();

  localparam int db_cycles       = 8;      // short debounce for simulation
  localparam int hb_half         = 20;     // short heartbeat half period
  localparam int watchdog_cycles = 20000;  // all tests need well under this

  typedef struct packed {
    logic [axil_addr_w-1:0] addr;
    logic [axil_data_w-1:0] exp_data;
    logic [1:0]             exp_resp;
    logic [axil_data_w-1:0] got_data;
    logic [1:0]             got_resp;
  } read_rec_t;

  logic                     fpga_clk_50;
  logic                     hps_fpga_reset_n;
  logic [num_keys-1:0]      key;
  logic [num_switches-1:0]  sw;
  logic [9:0]               ledr;
  axil_req_t                bus_req;
  axil_rsp_t                bus_rsp;
  hps_reset_req_t           hps_reset_pulse;
  stm_events_t              stm_hw_events;
  logic [2:0]               pulse_bits;

  // model of what the registers should hold
  logic [num_user_leds-1:0] led_shadow;
  logic [2:0]               rst_shadow;
  logic [num_keys-1:0]      key_model;    // 1 = pressed

  read_rec_t read_q [$];                  // finished reads waiting for compare
  int        seed          = 32'he350;
  int        cycle         = 0;
  int        wr_hs_cycle   = 0;           // cycle of the last write handshake
  int        err_cnt       = 0;
  int        test_err_base = 0;
  int        test_cnt      = 0;
  int        reads_checked = 0;
  int        pulse_start [3];
  int        pulse_seen  [3];
  int        pulse_rises [3] = '{0, 0, 0};
  logic [2:0] pulse_prev = '0;

  ghrd_fabric_top #(
    .debounce_cycles (db_cycles),
    .heartbeat_half  (hb_half)
  ) ghrd_fabric_top_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .sw               (sw),
    .ledr             (ledr),
    .bus_req          (bus_req),
    .bus_rsp          (bus_rsp),
    .hps_reset_pulse  (hps_reset_pulse),
    .stm_hw_events    (stm_hw_events)
  );

  assign pulse_bits = hps_reset_pulse;  // bit 0 cold, 1 warm, 2 debug

  // ========================================
  // clock, cycle count, watchdog
  // ========================================
  initial
  begin
    fpga_clk_50 = 1'b0;
    forever #2 fpga_clk_50 = ~fpga_clk_50;  // 4 ns period
  end

  always @(posedge fpga_clk_50)
    cycle <= cycle + 1;

  initial
  begin
    repeat (watchdog_cycles) @(posedge fpga_clk_50);
    $display("timeout: tests still running after %0d cycles", watchdog_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

  // ========================================
  // reference model and checks
  // ========================================
  // expected data and response for an access at addr
  function automatic void ref_access(input logic [axil_addr_w-1:0] addr,
                                     output logic [axil_data_w-1:0] data,
                                     output logic [1:0] resp);
    data = '0;
    resp = resp_okay;
    if (addr[1:0] != 2'b00)
      resp = resp_slverr;  // off the word grid so reads zero
    else if (addr == reg_led_addr)
      data[num_user_leds-1:0] = led_shadow;
    else if (addr == reg_sw_addr)
      data[num_switches-1:0] = sw;
    else if (addr == reg_key_addr)
      data[num_keys-1:0] = key_model;
    else
      data[2:0] = rst_shadow;
  endfunction

  // register effect of a write per byte lane
  function automatic void model_write(input logic [axil_addr_w-1:0] addr,
                                      input logic [axil_data_w-1:0] data,
                                      input logic [3:0] strb);
    if (addr == reg_led_addr)
    begin
      if (strb[0])
        led_shadow[7:0] = data[7:0];
      if (strb[1])
        led_shadow[8] = data[8];  // led 9 sits in byte 1
    end
    else if (addr == reg_rst_req_addr && strb[0])
      rst_shadow = data[2:0];
  endfunction

  function automatic int expected_pulse_len(input int b);
    case (b)
      0:       return cold_pulse_len;
      1:       return warm_pulse_len;
      default: return debug_pulse_len;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("FAILED %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond)
    else
    begin
      $display("error at %0t ns: %s", $time, what);
      err_cnt++;
    end
  endtask

  // compares every finished read against the model
  always @(negedge fpga_clk_50)
  begin : compare_reads
    read_rec_t rec;
    while (read_q.size() != 0)
    begin
      rec = read_q.pop_front();
      check_value($sformatf("rdata @0x%h", rec.addr), rec.got_data, rec.exp_data);
      check_value($sformatf("rresp @0x%h", rec.addr), 32'(rec.got_resp), 32'(rec.exp_resp));
      reads_checked++;
    end
  end

  // pulse start and length per request bit sampled mid-cycle
  always @(negedge fpga_clk_50)
  begin
    for (int b = 0; b < 3; b++)
    begin
      if (pulse_bits[b] && !pulse_prev[b])
      begin
        pulse_start[b] = cycle;
        pulse_seen[b]  = 1;
        pulse_rises[b]++;
      end
      else if (pulse_bits[b])
        pulse_seen[b]++;
    end
    pulse_prev = pulse_bits;
  end

  // ========================================
  // bus and stimulus tasks
  // ========================================
  task automatic axil_write(input logic [axil_addr_w-1:0] addr,
                            input logic [axil_data_w-1:0] data,
                            input logic [3:0] strb);
    logic [axil_data_w-1:0] unused_data;
    logic [1:0]             exp_resp;
    @(posedge fpga_clk_50);
    bus_req.awvalid <= 1'b1;
    bus_req.awaddr  <= addr;
    bus_req.wvalid  <= 1'b1;
    bus_req.wdata   <= data;
    bus_req.wstrb   <= strb;
    bus_req.bready  <= 1'b1;
    do @(negedge fpga_clk_50); while (!bus_rsp.awready);
    check_value("wready", 32'(bus_rsp.wready), 1);  // together with awready
    @(posedge fpga_clk_50);                 // handshake edge
    bus_req.awvalid <= 1'b0;
    bus_req.wvalid  <= 1'b0;
    @(negedge fpga_clk_50);
    wr_hs_cycle = cycle;
    while (!bus_rsp.bvalid)
      @(negedge fpga_clk_50);
    ref_access(addr, unused_data, exp_resp);
    check_value($sformatf("bresp @0x%h", addr), 32'(bus_rsp.bresp), 32'(exp_resp));
    model_write(addr, data, strb);
    @(posedge fpga_clk_50);                 // response taken here
    bus_req.bready <= 1'b0;
  endtask

  // stall = cycles of rready low once rvalid is up
  task automatic axil_read(input logic [axil_addr_w-1:0] addr, input int stall);
    read_rec_t rec;
    @(posedge fpga_clk_50);
    bus_req.arvalid <= 1'b1;
    bus_req.araddr  <= addr;
    bus_req.rready  <= (stall == 0);
    do @(negedge fpga_clk_50); while (!bus_rsp.arready);
    @(posedge fpga_clk_50);
    bus_req.arvalid <= 1'b0;
    do @(negedge fpga_clk_50); while (!bus_rsp.rvalid);
    rec.addr     = addr;
    rec.got_data = bus_rsp.rdata;
    rec.got_resp = bus_rsp.rresp;
    ref_access(addr, rec.exp_data, rec.exp_resp);
    read_q.push_back(rec);
    if (stall > 0)
    begin
      repeat (stall) @(posedge fpga_clk_50);  // hold off while rvalid must stay
      bus_req.rready <= 1'b1;
    end
    @(posedge fpga_clk_50);
    bus_req.rready <= 1'b0;
  endtask

  task automatic wait_buttons(input logic [num_keys-1:0] target, input string what);
    int n;
    n = 0;
    do
    begin
      @(negedge fpga_clk_50);
      n++;
    end
    while (stm_hw_events.buttons != target && n < 4 * db_cycles);
    check_true(stm_hw_events.buttons == target, what);
  endtask

  task automatic wait_pulse_end(input int b);
    do @(negedge fpga_clk_50); while (pulse_bits[b]);
  endtask

  task automatic finish_test(input string name);
    while (read_q.size() != 0)
      @(negedge fpga_clk_50);
    test_cnt++;
    $display("test %0d %s %s, %0d errors", test_cnt, name,
             (err_cnt == test_err_base) ? "passed" : "failed", err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  // ========================================
  // test sequence
  // ========================================
  initial
  begin : main_flow
    logic [31:0] rnd;
    logic [3:0]  strb;
    int          hs;
    int          rises_before;
    int          glen;
    int          prev_t;
    logic        lvl;

    hps_fpga_reset_n = 1'b0;
    key              = '1;   // released
    sw               = '0;
    bus_req          = '0;
    led_shadow       = '0;
    rst_shadow       = '0;
    key_model        = '0;
    repeat (10) @(posedge fpga_clk_50);
    hps_fpga_reset_n <= 1'b1;

    @(negedge fpga_clk_50);  // control outputs quiet after reset
    check_value("ledr", 32'(ledr), 0);
    check_value("hps_reset_pulse", 32'(pulse_bits), 0);
    check_value("bvalid,rvalid", 32'({bus_rsp.bvalid, bus_rsp.rvalid}), 0);
    finish_test("reset");

    // LED register with full words then random byte strobes
    for (int i = 0; i < 12; i++)
    begin
      rnd  = $random(seed);
      strb = (i < 6) ? 4'hF : 4'($random(seed));
      axil_write(reg_led_addr, rnd, strb);
      axil_read(reg_led_addr, i % 3);
      @(negedge fpga_clk_50);
      check_value("ledr[9:1]", 32'(ledr[9:1]), 32'(led_shadow));
      check_value("stm user_leds", 32'(stm_hw_events.user_leds), 32'(led_shadow));
    end
    finish_test("led");

    // switches read back and in the trace word
    for (int i = 0; i < 8; i++)
    begin
      rnd = $random(seed);
      @(posedge fpga_clk_50);
      sw <= rnd[num_switches-1:0];
      axil_read(reg_sw_addr, 0);
      @(negedge fpga_clk_50);
      check_value("stm switches", 32'(stm_hw_events.switches), 32'(sw));
      check_value("stm reserved", 32'(stm_hw_events.reserved), 0);
    end
    finish_test("switches");

    // short key glitch must vanish and bounce then hold must register
    for (int k = 0; k < num_keys; k++)
    begin
      glen = 1 + ($unsigned($random(seed)) % (db_cycles - 1));
      @(posedge fpga_clk_50);
      key[k] <= 1'b0;
      repeat (glen) @(posedge fpga_clk_50);
      key[k] <= 1'b1;
      repeat (db_cycles + 4)
      begin
        @(negedge fpga_clk_50);
        check_value("stm buttons", 32'(stm_hw_events.buttons), 32'(key_model));
      end
      axil_read(reg_key_addr, 0);
      @(posedge fpga_clk_50);
      key[k] <= 1'b0;        // bounce
      repeat (3) @(posedge fpga_clk_50);
      key[k] <= 1'b1;
      repeat (2) @(posedge fpga_clk_50);
      key[k] <= 1'b0;        // now held
      wait_buttons(key_model | 4'(1 << k), "held key never showed as pressed");
      key_model[k] = 1'b1;
      axil_read(reg_key_addr, 0);
      @(posedge fpga_clk_50);
      key[k] <= 1'b1;
      wait_buttons(key_model & ~4'(1 << k), "released key never showed as released");
      key_model[k] = 1'b0;
    end
    finish_test("keys");

    // reset requests one bit at a time
    for (int b = 0; b < 3; b++)
    begin
      rises_before = pulse_rises[b];
      axil_write(reg_rst_req_addr, 32'(1 << b), 4'h1);
      hs = wr_hs_cycle;
      if (b == 2)
      begin
        // drop and raise again mid-pulse without stretching it
        axil_write(reg_rst_req_addr, 32'h0, 4'h1);
        axil_write(reg_rst_req_addr, 32'h4, 4'h1);
      end
      wait_pulse_end(b);
      check_value($sformatf("pulse %0d start", b), pulse_start[b], hs + 1);
      check_value($sformatf("pulse %0d length", b), pulse_seen[b], expected_pulse_len(b));
      check_value($sformatf("pulse %0d count", b), pulse_rises[b], rises_before + 1);
      axil_read(reg_rst_req_addr, 0);
    end
    finish_test("rst_req");

    // heartbeat period
    @(negedge fpga_clk_50);
    prev_t = 0;
    for (int i = 0; i < 5; i++)
    begin
      lvl = ledr[0];
      do @(negedge fpga_clk_50); while (ledr[0] == lvl);
      if (i > 0)
        check_value("heartbeat half period", cycle - prev_t, hb_half);
      prev_t = cycle;
    end
    finish_test("heartbeat");

    // unaligned offsets give SLVERR and no side effects
    rises_before = pulse_rises[0] + pulse_rises[1] + pulse_rises[2];
    rnd = $random(seed);
    axil_write(4'h1, rnd, 4'hF);
    axil_write(4'hD, 32'h7, 4'hF);
    axil_write(4'h6, rnd, 4'hF);
    axil_read(4'h1, 0);
    axil_read(4'h6, 1);
    axil_read(4'hF, 0);
    axil_read(reg_led_addr, 0);
    axil_read(reg_rst_req_addr, 0);
    repeat (4) @(negedge fpga_clk_50);
    check_value("ledr[9:1]", 32'(ledr[9:1]), 32'(led_shadow));
    check_value("pulse count", pulse_rises[0] + pulse_rises[1] + pulse_rises[2],
                rises_before);
    finish_test("unmapped");

    $display("%0d tests, %0d reads checked, %0d errors", test_cnt, reads_checked, err_cnt);
    if (err_cnt == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== sim/ghrd_fabric_asserts.sv ====
/*
  Concurrent checks bound into the register block and the pulse
  generators. Bus responses must hold until taken, and each reset
  pulse must last exactly its pulse length.
*/
`timescale 1ns/1ns

module ghrd_fabric_asserts #(
  parameter int pulse_len = 1
)
(
  input logic fpga_clk_50,
  input logic hps_fpga_reset_n,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready,
  input logic pulse
);

  int high_cnt;  // cycles the pulse has been high so far

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
      high_cnt <= 0;
    else if (pulse)
      high_cnt <= high_cnt + 1;
    else
      high_cnt <= 0;
  end

  // ========================================
  // response hold and pulse width
  // ========================================
  bvalid_held: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  rvalid_held: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

  pulse_not_long: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    pulse |-> high_cnt < pulse_len)
    else $error("reset pulse longer than %0d cycles", pulse_len);

  pulse_exact: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    $fell(pulse) |-> high_cnt == pulse_len)
    else $error("reset pulse lasted %0d cycles, not %0d", high_cnt, pulse_len);

endmodule

bind pio_axil_regs ghrd_fabric_asserts bus_asserts_i (
  .fpga_clk_50      (fpga_clk_50),
  .hps_fpga_reset_n (hps_fpga_reset_n),
  .bvalid           (bus_rsp.bvalid),
  .bready           (bus_req.bready),
  .rvalid           (bus_rsp.rvalid),
  .rready           (bus_req.rready),
  .pulse            (1'b0)
);

bind reset_req_pulse ghrd_fabric_asserts #(.pulse_len(pulse_len)) pulse_asserts_i (
  .fpga_clk_50      (fpga_clk_50),
  .hps_fpga_reset_n (hps_fpga_reset_n),
  .bvalid           (1'b0),
  .bready           (1'b0),
  .rvalid           (1'b0),
  .rready           (1'b0),
  .pulse            (req_pulse)
);

// ==== hw/ghrd_fabric_top.sv ====
/*
  Fabric side of the SoC board top level.
  Debounces the keys, serves the LED/switch/button/reset-request
  registers over AXI4-Lite, shapes the cold, warm and debug reset
  requests into pulses, blinks the heartbeat on ledr[0] and packs
  the STM trace word. Timing parameters shrink for simulation.
*/
`timescale 1ns/1ns

module ghrd_fabric_top
  import fpga_pkg::*;
#(
  parameter int debounce_cycles = debounce_cycles_default,
  parameter int heartbeat_half  = heartbeat_half_default
)
(
  input  logic                    fpga_clk_50,
  input  logic                    hps_fpga_reset_n,
  input  logic [num_keys-1:0]     key,             // raw, active low
  input  logic [num_switches-1:0] sw,
  output logic [9:0]              ledr,
  input  axil_req_t               bus_req,
  output axil_rsp_t               bus_rsp,
  output hps_reset_req_t          hps_reset_pulse,
  output stm_events_t             stm_hw_events
);

  logic [num_keys-1:0]      debounced_buttons;  // 1 = pressed
  logic [num_user_leds-1:0] user_leds;
  hps_reset_req_t           rst_req_level;
  logic                     heartbeat;

  key_debounce #(.debounce_cycles(debounce_cycles)) key_debounce_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key_raw          (key),
    .key_pressed      (debounced_buttons)
  );

  pio_axil_regs pio_axil_regs_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .bus_req          (bus_req),
    .bus_rsp          (bus_rsp),
    .switches         (sw),
    .buttons          (debounced_buttons),
    .user_leds        (user_leds),
    .rst_req_level    (rst_req_level)
  );

  // ========================================
  // reset-request pulses, one per kind
  // ========================================
  reset_req_pulse #(.pulse_len(cold_pulse_len)) pulse_cold_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req_level        (rst_req_level.cold),
    .req_pulse        (hps_reset_pulse.cold)
  );

  reset_req_pulse #(.pulse_len(warm_pulse_len)) pulse_warm_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req_level        (rst_req_level.warm),
    .req_pulse        (hps_reset_pulse.warm)
  );

  reset_req_pulse #(.pulse_len(debug_pulse_len)) pulse_debug_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req_level        (rst_req_level.debug),
    .req_pulse        (hps_reset_pulse.debug)
  );

  heartbeat_led #(.heartbeat_half(heartbeat_half)) heartbeat_led_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .led_level        (heartbeat)
  );

  assign ledr = {user_leds, heartbeat};  // processor LEDs over the heartbeat

  // trace word for the STM
  assign stm_hw_events.reserved  = '0;
  assign stm_hw_events.switches  = sw;
  assign stm_hw_events.user_leds = user_leds;
  assign stm_hw_events.buttons   = debounced_buttons;

endmodule

// ==== hw/pio_axil_regs.sv ====
/*
  AXI4-Lite slave for the processor-visible peripheral registers.
  Holds the user LED register and the reset-request levels, and reads
  back the switches and the debounced buttons. One write and one read
  may be outstanding at a time. Unaligned offsets get SLVERR.
*/
`timescale 1ns/1ns

module pio_axil_regs
  import fpga_pkg::*;
(
  input  logic                     fpga_clk_50,
  input  logic                     hps_fpga_reset_n,
  input  axil_req_t                bus_req,
  output axil_rsp_t                bus_rsp,
  input  logic [num_switches-1:0]  switches,
  input  logic [num_keys-1:0]      buttons,
  output logic [num_user_leds-1:0] user_leds,
  output hps_reset_req_t           rst_req_level
);

  logic [num_user_leds-1:0] led_q;
  hps_reset_req_t           rst_req_q;
  logic                     bvalid_q;
  logic [1:0]               bresp_q;
  logic                     rvalid_q;
  logic [axil_data_w-1:0]   rdata_q;
  logic [1:0]               rresp_q;

  logic                     wr_fire;   // aw and w accepted this cycle
  logic                     rd_fire;   // ar accepted this cycle
  logic                     aw_mapped;
  logic                     ar_mapped;
  logic [axil_data_w-1:0]   rd_data;

  // accept only with no response waiting, so bready/rready stall us
  assign wr_fire   = bus_req.awvalid & bus_req.wvalid & ~bvalid_q;
  assign rd_fire   = bus_req.arvalid & ~rvalid_q;
  assign aw_mapped = (bus_req.awaddr[1:0] == 2'b00);  // word offsets only
  assign ar_mapped = (bus_req.araddr[1:0] == 2'b00);

  // ========================================
  // write channel and registers
  // ========================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      led_q     <= '0;
      rst_req_q <= '0;
      bvalid_q  <= 1'b0;
    end
    else if (wr_fire)
    begin
      bvalid_q <= 1'b1;
      if (bus_req.awaddr == reg_led_addr)
      begin
        if (bus_req.wstrb[0])
          led_q[7:0] <= bus_req.wdata[7:0];
        if (bus_req.wstrb[1])
          led_q[num_user_leds-1:8] <= bus_req.wdata[num_user_leds-1:8];
      end
      if (bus_req.awaddr == reg_rst_req_addr && bus_req.wstrb[0])
        rst_req_q <= hps_reset_req_t'(bus_req.wdata[2:0]);
    end
    else if (bus_req.bready)
      bvalid_q <= 1'b0;  // response taken
  end

  always_ff @(posedge fpga_clk_50)
  begin
    if (wr_fire)
      bresp_q <= aw_mapped ? resp_okay : resp_slverr;
  end

  // ========================================
  // read channel
  // ========================================
  always_comb
  begin
    rd_data = '0;  // unmapped reads as zero
    case (bus_req.araddr)
      reg_led_addr:     rd_data[num_user_leds-1:0] = led_q;
      reg_sw_addr:      rd_data[num_switches-1:0]  = switches;
      reg_key_addr:     rd_data[num_keys-1:0]      = buttons;
      reg_rst_req_addr: rd_data[2:0]               = rst_req_q;
      default:          rd_data = '0;
    endcase
  end

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
      rvalid_q <= 1'b0;
    else if (rd_fire)
      rvalid_q <= 1'b1;
    else if (bus_req.rready)
      rvalid_q <= 1'b0;
  end

  always_ff @(posedge fpga_clk_50)
  begin
    if (rd_fire)
    begin
      rdata_q <= rd_data;  // held until rready
      rresp_q <= ar_mapped ? resp_okay : resp_slverr;
    end
  end

  assign bus_rsp.awready = wr_fire;
  assign bus_rsp.wready  = wr_fire;
  assign bus_rsp.bvalid  = bvalid_q;
  assign bus_rsp.bresp   = bresp_q;
  assign bus_rsp.arready = rd_fire;
  assign bus_rsp.rvalid  = rvalid_q;
  assign bus_rsp.rdata   = rdata_q;
  assign bus_rsp.rresp   = rresp_q;

  assign user_leds     = led_q;
  assign rst_req_level = rst_req_q;

endmodule

// ==== hw/heartbeat_led.sv ====
/*
  Heartbeat for ledr[0]. The level flips every heartbeat_half cycles,
  so the LED blinks at 1 Hz with the default half period.
*/
`timescale 1ns/1ns

module heartbeat_led
  import fpga_pkg::*;
#(
  parameter int heartbeat_half = heartbeat_half_default
)
(
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  output logic led_level
);

  localparam int cnt_w = $clog2(heartbeat_half);

  logic [cnt_w-1:0] half_cnt;

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      half_cnt  <= '0;
      led_level <= 1'b0;
    end
    else if (half_cnt == cnt_w'(heartbeat_half - 1))
    begin
      half_cnt  <= '0;
      led_level <= ~led_level;  // wrap, flip the LED
    end
    else
      half_cnt <= half_cnt + 1'b1;
  end

endmodule

// ==== hw/reset_req_pulse.sv ====
/*
  Turns a reset-request level into a fixed-length pulse.
  A rising edge on req_level starts a pulse one cycle later that lasts
  exactly pulse_len cycles. Edges seen while a pulse runs are dropped,
  so a request cannot stretch a reset already in progress.
*/
`timescale 1ns/1ns

module reset_req_pulse #(
  parameter int pulse_len = 2
)
(
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic req_level,
  output logic req_pulse
);

  localparam int cnt_w = $clog2(pulse_len + 1);

  logic             level_q;   // previous level for edge detect
  logic             rise;
  logic [cnt_w-1:0] pulse_cnt; // cycles of pulse left
  logic             busy;

  assign rise = req_level & ~level_q;
  assign busy = (pulse_cnt != '0);

  // ========================================
  // edge detect and down-counter
  // ========================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      level_q   <= 1'b0;
      pulse_cnt <= '0;
    end
    else
    begin
      level_q <= req_level;
      if (busy)
        pulse_cnt <= pulse_cnt - 1'b1;  // running, new edges ignored
      else if (rise)
        pulse_cnt <= cnt_w'(pulse_len); // idle, arm a new pulse
    end
  end

  // high while the counter is non-zero, pulse_len cycles in all
  assign req_pulse = busy;

endmodule

// ==== hw/key_debounce.sv ====
/*
  Stability filter for the active-low push buttons.
  Each key is synchronized, then its accepted level only follows the
  raw level once that has held for debounce_cycles cycles in a row.
  Output is 1 while a key is pressed.
*/
`timescale 1ns/1ns

module key_debounce
  import fpga_pkg::*;
#(
  parameter int debounce_cycles = debounce_cycles_default
)
(
  input  logic                fpga_clk_50,
  input  logic                hps_fpga_reset_n,
  input  logic [num_keys-1:0] key_raw,
  output logic [num_keys-1:0] key_pressed
);

  localparam int cnt_w = $clog2(debounce_cycles + 1);

  logic [num_keys-1:0] key_meta;   // first sync stage
  logic [num_keys-1:0] key_sync;   // second sync stage
  logic [num_keys-1:0] key_level;  // accepted level, still active low
  logic [cnt_w-1:0]    stable_cnt [num_keys];

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_meta  <= '1;  // released
      key_sync  <= '1;
      key_level <= '1;
      for (int i = 0; i < num_keys; i++)
        stable_cnt[i] <= '0;
    end
    else
    begin
      key_meta <= key_raw;
      key_sync <= key_meta;
      for (int i = 0; i < num_keys; i++)
      begin
        if (key_sync[i] == key_level[i])
          stable_cnt[i] <= '0;  // bounce back, start over
        else if (stable_cnt[i] == cnt_w'(debounce_cycles - 1))
        begin
          key_level[i]  <= key_sync[i];  // held long enough, accept
          stable_cnt[i] <= '0;
        end
        else
          stable_cnt[i] <= stable_cnt[i] + 1'b1;
      end
    end
  end

  assign key_pressed = ~key_level;  // 1 = pressed

endmodule

// ==== hw/fpga_pkg.sv ====
/*
  Shared definitions for the fabric side of the SoC board top level.
  Holds the AXI4-Lite register map, the timing constants for debounce,
  heartbeat and reset-request pulses, and the bus and trace structs.
  Modules take it by a wildcard import in their header.
*/
package fpga_pkg;

  // ========================================
  // board widths and bus geometry
  // ========================================
  localparam int num_keys      = 4;   // push buttons, active low
  localparam int num_switches  = 10;  // slide switches
  localparam int num_user_leds = 9;   // ledr[9:1], ledr[0] is the heartbeat
  localparam int axil_addr_w   = 4;
  localparam int axil_data_w   = 32;

  // register map, word aligned
  localparam logic [axil_addr_w-1:0] reg_led_addr     = 4'h0; // rw, bits 8..0
  localparam logic [axil_addr_w-1:0] reg_sw_addr      = 4'h4; // ro, bits 9..0
  localparam logic [axil_addr_w-1:0] reg_key_addr     = 4'h8; // ro, 1 = pressed
  localparam logic [axil_addr_w-1:0] reg_rst_req_addr = 4'hC; // rw, cold/warm/debug

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // ========================================
  // timing, in fpga_clk_50 cycles
  // ========================================
  localparam int debounce_cycles_default = 50000;    // 1 ms
  localparam int heartbeat_half_default  = 25000000; // 0.5 s
  localparam int cold_pulse_len  = 6;
  localparam int warm_pulse_len  = 2;
  localparam int debug_pulse_len = 32;

  // master-driven AXI4-Lite fields
  typedef struct packed {
    logic                     awvalid;
    logic [axil_addr_w-1:0]   awaddr;
    logic                     wvalid;
    logic [axil_data_w-1:0]   wdata;
    logic [axil_data_w/8-1:0] wstrb;
    logic                     bready;
    logic                     arvalid;
    logic [axil_addr_w-1:0]   araddr;
    logic                     rready;
  } axil_req_t;

  // slave-driven AXI4-Lite fields
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [axil_data_w-1:0] rdata;
    logic [1:0]             rresp;
  } axil_rsp_t;

  // bit 0 cold, bit 1 warm, bit 2 debug
  typedef struct packed {
    logic debug;
    logic warm;
    logic cold;
  } hps_reset_req_t;

  // trace word to the STM, top bits tied to zero
  typedef struct packed {
    logic [4:0]               reserved;
    logic [num_switches-1:0]  switches;
    logic [num_user_leds-1:0] user_leds;
    logic [num_keys-1:0]      buttons;
  } stm_events_t;

endpackage
